//--- logic/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

////////////////////
// clock dividers
////////////////////

// width of both divider registers.
`define UART_DIV_W 16

// clocks per bit after reset.
`define UART_DIV_RESET 16'd217

////////////////////
// register map
////////////////////

// status, read only.
`define UART_ADDR_STATUS 2'b00
// rx byte on read, tx start on write.
`define UART_ADDR_DATA 2'b01
// rx clocks per bit.
`define UART_ADDR_RXDIV 2'b10
// tx clocks per bit.
`define UART_ADDR_TXDIV 2'b11

`endif

//--- logic/uartBusPkg.sv
`default_nettype none

package uartBusPkg;

	////////////////////
	// host bus
	////////////////////

	// one host access, valid for the single cycle its strobe is high.
	// no wait states and no back-pressure on this bus.
	typedef struct packed {
		// read strobe.
		logic        rd;
		// write strobe.
		logic        wr;
		// register select.
		logic [1:0]  addr;
		// write data, dividers use all of it.
		logic [15:0] wrData;
	} busReq_t;

endpackage : uartBusPkg

`default_nettype wire

//--- logic/uartRegPkg.sv
`default_nettype none

package uartRegPkg;

	////////////////////
	// status and read word
	////////////////////

	// status register layout.
	typedef struct packed {
		logic [12:0] reserved;
		logic        txDone;
		logic        txActive;
		logic        rxAvail;
	} statusFlags_t;

	// read data, either a plain word or the status flags.
	typedef union packed {
		logic [15:0]  raw;
		statusFlags_t flags;
	} regWord_u;

	////////////////////
	// receiver output
	////////////////////

	// one completed frame, valid for one cycle.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rxEvent_t;

endpackage : uartRegPkg

`default_nettype wire

//--- logic/uartRx.sv
`default_nettype none

`include "uart_params.svh"

module uartRx (
	input  wire logic                   CLK,
	input  wire logic                   RESET,
	input  wire logic                   i_rxd,
	input  wire logic [`UART_DIV_W-1:0] i_div,
	output uartRegPkg::rxEvent_t        o_rxEvent
);

	typedef enum logic [1:0] {
		idle,
		startBit,
		dataBits,
		stopBit
	} rxState_t;

	rxState_t               state;
	logic [1:0]             rxSync;
	logic                   rxBit;
	logic [`UART_DIV_W-1:0] cnt;
	logic                   bitEnd;
	logic [2:0]             bitIdx;
	logic [7:0]             shiftReg;
	logic                   rxValid;

	// two flops on the async serial line, idle high.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], i_rxd};
		end
	end

	assign rxBit = rxSync[1];
	assign bitEnd = (cnt == i_div - 1'b1);

	////////////////////
	// frame fsm
	////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state <= idle;
			cnt <= '0;
			bitIdx <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			case (state)
				idle: begin
					cnt <= '0;
					if (!rxBit) begin
						state <= startBit;
					end
				end
				// recheck the line half a bit in, glitches go back to idle.
				startBit: begin
					if (cnt == (i_div >> 1)) begin
						cnt <= '0;
						bitIdx <= '0;
						state <= rxBit ? idle : dataBits;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				dataBits: begin
					if (bitEnd) begin
						cnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) begin
							state <= stopBit;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				// a low stop bit drops the frame.
				stopBit: begin
					if (bitEnd) begin
						rxValid <= rxBit;
						cnt <= '0;
						state <= idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// lsb first, so shift in from the top.
	always_ff @(posedge CLK) begin
		if (state == dataBits && bitEnd) begin
			shiftReg <= {rxBit, shiftReg[7:1]};
		end
	end

	assign o_rxEvent.valid = rxValid;
	assign o_rxEvent.data = shiftReg;

endmodule : uartRx

`default_nettype wire

//--- logic/uartTx.sv
`default_nettype none

`include "uart_params.svh"

module uartTx (
	input  wire logic                   CLK,
	input  wire logic                   RESET,
	input  wire logic                   i_start,
	input  wire logic [7:0]             i_byte,
	input  wire logic [`UART_DIV_W-1:0] i_div,
	output logic                        o_txd,
	output logic                        o_txActive,
	output logic                        o_txDone
);

	typedef enum logic [1:0] {
		idle,
		startBit,
		dataBits,
		stopBit
	} txState_t;

	txState_t               state;
	logic [`UART_DIV_W-1:0] cnt;
	logic                   bitEnd;
	logic [2:0]             bitIdx;
	logic [7:0]             txByte;

	assign bitEnd = (cnt == i_div - 1'b1);

	// byte is held for the whole frame.
	always_ff @(posedge CLK) begin
		if (state == idle && i_start) begin
			txByte <= i_byte;
		end
	end

	////////////////////
	// frame fsm
	////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state <= idle;
			cnt <= '0;
			bitIdx <= '0;
			o_txd <= 1'b1;
			o_txActive <= 1'b0;
			o_txDone <= 1'b0;
		end else begin
			o_txDone <= 1'b0;
			case (state)
				idle: begin
					cnt <= '0;
					if (i_start) begin
						o_txd <= 1'b0;
						o_txActive <= 1'b1;
						state <= startBit;
					end
				end
				startBit: begin
					if (bitEnd) begin
						cnt <= '0;
						bitIdx <= '0;
						o_txd <= txByte[0];
						state <= dataBits;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				dataBits: begin
					if (bitEnd) begin
						cnt <= '0;
						if (bitIdx == 3'd7) begin
							o_txd <= 1'b1;
							state <= stopBit;
						end else begin
							bitIdx <= bitIdx + 1'b1;
							o_txd <= txByte[bitIdx + 3'd1];
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				// end of stop bit, single done pulse.
				stopBit: begin
					if (bitEnd) begin
						cnt <= '0;
						o_txActive <= 1'b0;
						o_txDone <= 1'b1;
						state <= idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule : uartTx

`default_nettype wire

//--- logic/uartRegs.sv
`default_nettype none

`include "uart_params.svh"

module uartRegs (
	input  wire logic                   CLK,
	input  wire logic                   RESET,
	input  wire uartBusPkg::busReq_t    i_bus,
	output uartRegPkg::regWord_u        o_rdData,
	output logic                        o_int,
	input  wire uartRegPkg::rxEvent_t   i_rxEvent,
	output logic [`UART_DIV_W-1:0]      o_rxDiv,
	output logic [`UART_DIV_W-1:0]      o_txDiv,
	output logic                        o_txStart,
	output logic [7:0]                  o_txByte,
	input  wire logic                   i_txActive,
	input  wire logic                   i_txDone
);

	import uartRegPkg::*;

	logic         rxAvail;
	logic         txActiveR;
	logic         txDoneR;
	logic [7:0]   rxByte;
	logic         dataRead;
	logic         dataWrite;
	logic         txAccept;
	statusFlags_t flags;
	regWord_u     rdNext;

	assign dataRead = i_bus.rd && (i_bus.addr == `UART_ADDR_DATA);
	assign dataWrite = i_bus.wr && (i_bus.addr == `UART_ADDR_DATA);

	// busy transmitter or pending start, the byte is dropped.
	assign txAccept = dataWrite && !i_txActive && !o_txStart;

	////////////////////
	// status latches and control
	////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rxAvail <= 1'b0;
			txActiveR <= 1'b0;
			txDoneR <= 1'b0;
			o_txStart <= 1'b0;
			o_rxDiv <= `UART_DIV_RESET;
			o_txDiv <= `UART_DIV_RESET;
		end else begin
			txActiveR <= i_txActive;
			// a new byte beats a read in the same cycle.
			if (i_rxEvent.valid) begin
				rxAvail <= 1'b1;
			end else if (dataRead) begin
				rxAvail <= 1'b0;
			end
			// the write clear wins over a done pulse.
			if (dataWrite) begin
				txDoneR <= 1'b0;
			end else if (i_txDone) begin
				txDoneR <= 1'b1;
			end
			// start held until the core reports active.
			if (txAccept) begin
				o_txStart <= 1'b1;
			end else if (i_txActive) begin
				o_txStart <= 1'b0;
			end
			if (i_bus.wr && i_bus.addr == `UART_ADDR_RXDIV) begin
				o_rxDiv <= i_bus.wrData[`UART_DIV_W-1:0];
			end
			if (i_bus.wr && i_bus.addr == `UART_ADDR_TXDIV) begin
				o_txDiv <= i_bus.wrData[`UART_DIV_W-1:0];
			end
		end
	end

	// data registers.
	always_ff @(posedge CLK) begin
		if (i_rxEvent.valid) begin
			rxByte <= i_rxEvent.data;
		end
		if (txAccept) begin
			o_txByte <= i_bus.wrData[7:0];
		end
	end

	////////////////////
	// read path
	////////////////////

	assign flags = '{reserved: '0, txDone: txDoneR, txActive: txActiveR, rxAvail: rxAvail};

	always_comb begin
		rdNext.raw = '0;
		case (i_bus.addr)
			`UART_ADDR_STATUS: rdNext.flags = flags;
			`UART_ADDR_DATA:   rdNext.raw = {8'h00, rxByte};
			`UART_ADDR_RXDIV:  rdNext.raw = o_rxDiv;
			`UART_ADDR_TXDIV:  rdNext.raw = o_txDiv;
			default:           rdNext.raw = '0;
		endcase
	end

	// holds until the next read.
	always_ff @(posedge CLK) begin
		if (i_bus.rd) begin
			o_rdData <= rdNext;
		end
	end

	// level interrupt.
	assign o_int = rxAvail | txDoneR;

endmodule : uartRegs

`default_nettype wire

//--- logic/uartPeripheral.sv
`default_nettype none

`include "uart_params.svh"

module uartPeripheral (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire uartBusPkg::busReq_t  i_bus,
	output uartRegPkg::regWord_u      o_rdData,
	output logic                      o_int,
	input  wire logic                 i_rxd,
	output logic                      o_txd
);

	import uartRegPkg::*;

	rxEvent_t               rxEvent;
	logic [`UART_DIV_W-1:0] rxDiv;
	logic [`UART_DIV_W-1:0] txDiv;
	logic                   txStart;
	logic [7:0]             txByte;
	logic                   txActive;
	logic                   txDone;

	// host side registers.
	uartRegs regsInst (
		.CLK(CLK),
		.RESET(RESET),
		.i_bus(i_bus),
		.o_rdData(o_rdData),
		.o_int(o_int),
		.i_rxEvent(rxEvent),
		.o_rxDiv(rxDiv),
		.o_txDiv(txDiv),
		.o_txStart(txStart),
		.o_txByte(txByte),
		.i_txActive(txActive),
		.i_txDone(txDone)
	);

	uartRx rxInst (
		.CLK(CLK),
		.RESET(RESET),
		.i_rxd(i_rxd),
		.i_div(rxDiv),
		.o_rxEvent(rxEvent)
	);

	uartTx txInst (
		.CLK(CLK),
		.RESET(RESET),
		.i_start(txStart),
		.i_byte(txByte),
		.i_div(txDiv),
		.o_txd(o_txd),
		.o_txActive(txActive),
		.o_txDone(txDone)
	);

endmodule : uartPeripheral

`default_nettype wire

//--- sim/uartPeripheral_sva.sv
`default_nettype none

`include "uart_params.svh"

module uartPeripheral_sva (
	input wire logic                   CLK,
	input wire logic                   RESET,
	input wire logic                   i_int,
	input wire logic                   i_rxValid,
	input wire logic                   i_txDonePulse,
	input wire logic                   i_txStart,
	input wire logic                   i_txActive,
	input wire logic [`UART_DIV_W-1:0] i_rxDiv,
	input wire logic [`UART_DIV_W-1:0] i_txDiv
);

	timeunit 1ns;
	timeprecision 100ps;

	// interrupt rises only the cycle after a received byte or a finished frame.
	intRisesOnEvent: assert property (@(posedge CLK) disable iff (RESET)
		$rose(i_int) |-> $past(i_rxValid || i_txDonePulse))
		else $error("interrupt rose without a received byte or a finished frame");

	// a received byte always raises the interrupt.
	intSetByRx: assert property (@(posedge CLK) disable iff (RESET)
		i_rxValid |=> i_int)
		else $error("interrupt low the cycle after a received byte");

	// start request drops once the core is busy.
	startDropsOnActive: assert property (@(posedge CLK) disable iff (RESET)
		$rose(i_txActive) |-> ##2 !i_txStart)
		else $error("tx start still high two cycles after tx active rose");

	// strobes leave the registers alone under reset.
	resetHoldsRegs: assert property (@(posedge CLK)
		(RESET && $past(RESET)) |->
		(i_rxDiv == `UART_DIV_RESET && i_txDiv == `UART_DIV_RESET && !i_txStart))
		else $error("register changed while reset was high");

endmodule : uartPeripheral_sva

bind uartRegs uartPeripheral_sva svaInst (
	.CLK(CLK),
	.RESET(RESET),
	.i_int(o_int),
	.i_rxValid(i_rxEvent.valid),
	.i_txDonePulse(i_txDone),
	.i_txStart(o_txStart),
	.i_txActive(i_txActive),
	.i_rxDiv(o_rxDiv),
	.i_txDiv(o_txDiv)
);

`default_nettype wire

//--- sim/uartPeripheralTb.sv
`default_nettype none

`include "uart_params.svh"

module uartPeripheralTb;

	timeunit 1ns;
	timeprecision 100ps;

	import uartBusPkg::*;
	import uartRegPkg::*;

	localparam int NUM_TESTS = 5;
	localparam int MAX_DIV = 12;
	localparam int CYCLE_LIMIT = NUM_TESTS * 12 * 12 * MAX_DIV + 1000;
	localparam int MIX_OPS = 12;

	logic     CLK;
	logic     RESET;
	busReq_t  bus;
	regWord_u rdData;
	logic     intr;
	logic     rxd;
	logic     txd;

	// reference model.
	logic [`UART_DIV_W-1:0] expRxDiv;
	logic [`UART_DIV_W-1:0] expTxDiv;
	logic                   expRxAvail;
	logic                   expTxDone;
	logic [7:0]             expRxByte;

	logic [7:0]  txGot;
	int          errors;
	int          checks;
	int          testErrors;
	int          cycles;
	int unsigned seed;

	uartPeripheral dut_i (
		.CLK(CLK),
		.RESET(RESET),
		.i_bus(bus),
		.o_rdData(rdData),
		.o_int(intr),
		.i_rxd(rxd),
		.o_txd(txd)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped: no result after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic checkWord(input string name, input regWord_u got, input regWord_u exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
			testErrors++;
		end
	endtask

	task automatic checkFlags(input string name, input statusFlags_t got,
		input statusFlags_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			testErrors++;
		end
	endtask

	////////////////////
	// helpers
	////////////////////

	function automatic regWord_u wordOf(input logic [15:0] v);
		regWord_u w;
		w.raw = v;
		return w;
	endfunction

	function automatic statusFlags_t expFlags(input logic active);
		statusFlags_t f;
		f = '0;
		f.txDone = expTxDone;
		f.txActive = active;
		f.rxAvail = expRxAvail;
		return f;
	endfunction

	function automatic logic [15:0] randDiv();
		int unsigned r;
		r = $urandom_range(MAX_DIV, 4);
		return 16'(r);
	endfunction

	// all tasks start and end 1 ns after a rising edge.
	task automatic busWrite(input logic [1:0] addr, input logic [15:0] data);
		bus = '{rd: 1'b0, wr: 1'b1, addr: addr, wrData: data};
		@(posedge CLK);
		#1;
		bus = '0;
	endtask

	task automatic busRead(input logic [1:0] addr, output regWord_u word);
		bus = '{rd: 1'b1, wr: 1'b0, addr: addr, wrData: 16'h0000};
		@(posedge CLK);
		#1;
		bus = '0;
		word = rdData;
	endtask

	task automatic checkStatus(input string name, input logic active);
		regWord_u w;
		busRead(`UART_ADDR_STATUS, w);
		checkFlags(name, w.flags, expFlags(active));
	endtask

	// polls status until one flag bit is set.
	task automatic waitFlag(input int sel, input string what);
		regWord_u w;
		int n;
		n = 0;
		w.raw = '0;
		while (w.raw[sel] !== 1'b1 && n < 64) begin
			busRead(`UART_ADDR_STATUS, w);
			n++;
		end
		if (w.raw[sel] !== 1'b1) begin
			$display("%s flag never came up after %0d status reads", what, n);
			testErrors++;
		end
	endtask

	////////////////////
	// serial lines
	////////////////////

	task automatic sendRx(input logic [7:0] b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			rxd = frame[i];
			repeat (expRxDiv) @(posedge CLK);
			#1;
		end
	endtask

	// samples o_txd at bit centers.
	task automatic monitorTx(input int div);
		int i;
		txGot = '0;
		while (txd !== 1'b0) begin
			@(posedge CLK);
			#1;
		end
		repeat (div / 2) @(posedge CLK);
		#1;
		checkBit("o_txd start bit", txd, 1'b0);
		for (i = 0; i < 8; i++) begin
			repeat (div) @(posedge CLK);
			#1;
			txGot[i] = txd;
		end
		repeat (div) @(posedge CLK);
		#1;
		checkBit("o_txd stop bit", txd, 1'b1);
	endtask

	task automatic txFrame(input logic [7:0] b);
		busWrite(`UART_ADDR_DATA, {8'h00, b});
		expTxDone = 1'b0;
		fork
			monitorTx(int'(expTxDiv));
			begin
				repeat (2) @(posedge CLK);
				#1;
				checkStatus("status during tx", 1'b1);
			end
		join
		checkByte("o_txd byte", txGot, b);
		waitFlag(2, "tx done");
		expTxDone = 1'b1;
		checkStatus("status after tx", 1'b0);
		checkBit("o_int", intr, 1'b1);
	endtask

	task automatic rxFrame(input logic [7:0] b);
		sendRx(b);
		// an unread byte keeps the flag up, so let the frame settle.
		if (!expRxAvail) begin
			waitFlag(0, "rx available");
		end else begin
			repeat (2 * expRxDiv) @(posedge CLK);
			#1;
		end
		expRxAvail = 1'b1;
		expRxByte = b;
		checkStatus("status after rx", 1'b0);
		checkBit("o_int", intr, 1'b1);
	endtask

	task automatic readRx();
		regWord_u w;
		busRead(`UART_ADDR_DATA, w);
		checkWord("rx data", w, wordOf({8'h00, expRxByte}));
		expRxAvail = 1'b0;
		checkStatus("status after data read", 1'b0);
		checkBit("o_int", intr, expTxDone);
	endtask

	task automatic endTest(input string name);
		$display("test %s finished with %0d errors", name, testErrors);
		errors += testErrors;
		testErrors = 0;
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		regWord_u    w;
		logic [15:0] d;
		logic [31:0] r;
		int          i;
		int          op;
		seed = $urandom(64);
		RESET = 1'b1;
		bus = '0;
		rxd = 1'b1;
		errors = 0;
		checks = 0;
		testErrors = 0;
		cycles = 0;
		expRxDiv = `UART_DIV_RESET;
		expTxDiv = `UART_DIV_RESET;
		expRxAvail = 1'b0;
		expTxDone = 1'b0;
		expRxByte = '0;
		// random strobes under reset must leave every register alone.
		for (i = 0; i < 10; i++) begin
			r = $urandom();
			bus = r[19:0];
			@(posedge CLK);
			#1;
		end
		bus = '0;
		RESET = 1'b0;

		checkStatus("status after reset", 1'b0);
		busRead(`UART_ADDR_RXDIV, w);
		checkWord("rx divider", w, wordOf(expRxDiv));
		busRead(`UART_ADDR_TXDIV, w);
		checkWord("tx divider", w, wordOf(expTxDiv));
		checkBit("o_int", intr, 1'b0);
		checkBit("o_txd", txd, 1'b1);
		endTest("reset state");

		for (i = 0; i < 4; i++) begin
			r = $urandom();
			busWrite(`UART_ADDR_RXDIV, r[15:0]);
			busWrite(`UART_ADDR_TXDIV, r[31:16]);
			busRead(`UART_ADDR_RXDIV, w);
			checkWord("rx divider", w, wordOf(r[15:0]));
			busRead(`UART_ADDR_TXDIV, w);
			checkWord("tx divider", w, wordOf(r[31:16]));
		end
		r = $urandom();
		busWrite(`UART_ADDR_STATUS, r[15:0]);
		checkStatus("status after write", 1'b0);
		// short frames for the serial tests.
		expRxDiv = randDiv();
		expTxDiv = randDiv();
		busWrite(`UART_ADDR_RXDIV, expRxDiv);
		busWrite(`UART_ADDR_TXDIV, expTxDiv);
		endTest("divider registers");

		r = $urandom();
		txFrame(r[7:0]);
		txFrame(r[15:8]);
		endTest("transmit");

		r = $urandom();
		rxFrame(r[7:0]);
		readRx();
		endTest("receive");

		d = randDiv();
		busWrite(`UART_ADDR_RXDIV, d);
		expRxDiv = d;
		d = randDiv();
		busWrite(`UART_ADDR_TXDIV, d);
		expTxDiv = d;
		for (i = 0; i < MIX_OPS; i++) begin
			r = $urandom();
			op = $urandom_range(2, 0);
			if (op == 0) begin
				txFrame(r[7:0]);
			end else begin
				rxFrame(r[7:0]);
				// op 2 leaves the byte for the next one to overwrite.
				if (op == 1) begin
					readRx();
				end
			end
		end
		if (expRxAvail) begin
			readRx();
		end
		endTest("mixed stream");

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule : uartPeripheralTb

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/uartBusPkg.sv
logic/uartRegPkg.sv
logic/uartRx.sv
logic/uartTx.sv
logic/uartRegs.sv
logic/uartPeripheral.sv
sim/uartPeripheral_sva.sv
sim/uartPeripheralTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module uartPeripheralTb -f filelist.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Test completed successfully" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
